/* testbench/sfu_cases.txt */
// id | lane0..lane7 | last | lane-valid mask | expected0..expected7 (all hex)
// expected = min(ffff, floor(lane * floor(2^24 / sum) / 256)), reciprocal 0 when sum is 0
00 0100 0100 0100 0100 0100 0100 0100 0100 0 ff 2000 2000 2000 2000 2000 2000 2000 2000
01 0001 0001 0001 0001 0001 0001 0001 0001 1 ff 2000 2000 2000 2000 2000 2000 2000 2000
02 ffff ffff ffff ffff ffff ffff ffff ffff 0 ff 1fff 1fff 1fff 1fff 1fff 1fff 1fff 1fff
03 0400 0000 0000 0000 0000 0000 0000 0000 0 ff ffff 0000 0000 0000 0000 0000 0000 0000
04 1234 0000 0000 0000 0000 0000 0000 0000 1 ff fffb 0000 0000 0000 0000 0000 0000 0000
05 0000 0000 0000 0000 0000 0000 0000 0000 0 ff 0000 0000 0000 0000 0000 0000 0000 0000
06 0010 0020 0030 0040 0050 0060 0070 0080 1 ff 071c 0e38 1555 1c71 238e 2aaa 31c7 38e3
07 0800 0400 0200 0100 0080 0040 0020 0020 0 ff 8000 4000 2000 1000 0800 0400 0200 0200
08 ffff 0001 8000 4000 2000 1000 0800 0800 1 ff 7fff 0000 4000 2000 1000 0800 0400 0400
09 0003 0003 0003 0003 0003 0003 0003 0003 0 ff 1fff 1fff 1fff 1fff 1fff 1fff 1fff 1fff
0a 0000 0000 0000 0000 0000 0000 0000 0001 1 ff 0000 0000 0000 0000 0000 0000 0000 ffff
0b 0000 0000 0000 0000 0000 8000 0000 0000 0 ff 0000 0000 0000 0000 0000 ffff 0000 0000
0c 0000 0000 0001 0000 0000 0000 0001 0000 0 ff 0000 0000 8000 0000 0000 0000 8000 0000
0d 0005 0005 0005 0000 0000 0000 0000 0000 1 ff 5555 5555 5555 0000 0000 0000 0000 0000
0e f000 0800 0400 0200 0100 0080 0040 0040 0 ff f000 0800 0400 0200 0100 0080 0040 0040
0f 0100 0100 0100 0100 0100 0100 0100 0100 1 0f 2000 2000 2000 2000 2000 2000 2000 2000
10 4000 4000 4000 4000 4000 4000 4000 4000 1 ff 2000 2000 2000 2000 2000 2000 2000 2000
11 0002 0002 0002 0002 0000 0000 0000 0000 0 ff 4000 4000 4000 4000 0000 0000 0000 0000
12 0001 0001 0001 0001 0003 0003 0003 0003 1 ff 1000 1000 1000 1000 3000 3000 3000 3000
13 8000 8000 4000 4000 4000 4000 0000 0000 0 ff 4000 4000 2000 2000 2000 2000 0000 0000

/* project.f */
design/sfu_pkg.sv
design/vec_stream_if.sv
design/lane_capture.sv
design/sum_tree.sv
design/recip_div.sv
design/bypass_delay.sv
design/lane_scale.sv
design/result_collect.sv
design/sfu_top.sv
testbench/tb_sfu.sv

/* run_sim.sh */
#!/bin/sh
# Compile the RTL and testbench with Verilator, run, and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_sfu -f project.f -o tb_sfu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sfu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

/* testbench/tb_sfu.sv */
`default_nettype none

module tb_sfu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N         = 8;
    localparam int EW        = 16;
    localparam int FIELDS    = 2 * N + 3;  // Id, lanes, last, mask, expected lanes.
    localparam int NUM_CASES = 20;
    localparam int LATENCY   = 31;         // log2 N + 28.
    localparam int CAPACITY  = 31;         // Capture, 28 path stages, lane and output regs.
    localparam int QUIET     = 8;          // Idle cycles that must show no stray output.
    localparam int LIMIT     = NUM_CASES * 4 + LATENCY + 200;
    localparam int SEED      = 81;

    logic            clk;
    logic            rst;
    logic [N-1:0]    in_valid;
    logic [N-1:0]    in_last;
    logic [N*EW-1:0] in_data;
    logic            in_ready;
    logic            out_valid;
    logic            out_ready;
    logic            out_last;
    logic [N*EW-1:0] out_data;

    logic [15:0]     case_mem [NUM_CASES * FIELDS];
    int              cur_case;
    int              cycle;
    int              errors;
    int              tests_run;
    int              tests_failed;
    logic [N*EW-1:0] exp_data_q [$];
    logic            exp_last_q [$];
    int              exp_id_q [$];
    int              acc_cycles [$];
    int              out_cycles [$];

    sfu_top #(.N(N)) DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [15:0] case_field(int idx, int f);
        return case_mem[idx * FIELDS + f];
    endfunction

    function automatic logic [N-1:0] mask_of(int idx);
        logic [15:0] m;
        m = case_field(idx, N + 2);
        return m[N-1:0];
    endfunction

    function automatic logic [N*EW-1:0] expected_lanes(int idx);
        logic [N*EW-1:0] v;
        for (int i = 0; i < N; i++) begin
            v[i*EW +: EW] = case_field(idx, N + 3 + i);
        end
        return v;
    endfunction

    function automatic int next_full_case(int idx);
        int c;
        c = (idx + 1) % NUM_CASES;
        while (mask_of(c) != '1) begin
            c = (c + 1) % NUM_CASES;
        end
        return c;
    endfunction

    task automatic check_output(logic [N*EW-1:0] exp_data, logic exp_last, int id);
        for (int i = 0; i < N; i++) begin
            if (out_data[i*EW +: EW] !== exp_data[i*EW +: EW]) begin
                $display("[FAIL] t=%0t case %0h lane %0d: expected %h, got %h", $time, id, i,
                         exp_data[i*EW +: EW], out_data[i*EW +: EW]);
                errors++;
            end
        end
        if (out_last !== exp_last) begin
            $display("[FAIL] t=%0t case %0h last: expected %b, got %b", $time, id,
                     exp_last, out_last);
            errors++;
        end
    endtask

    // Scoreboard and cycle limit.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > LIMIT) begin
            $display("timeout: run went past %0d cycles", LIMIT);
            $display("sim failed");
            $finish;
        end else begin
            if (!rst && (&in_valid) && in_ready) begin
                exp_data_q.push_back(expected_lanes(cur_case));
                exp_last_q.push_back(case_field(cur_case, N + 1) != 16'h0000);
                exp_id_q.push_back(cur_case);
                acc_cycles.push_back(cycle);
            end
            if (!rst && out_valid && out_ready) begin
                out_cycles.push_back(cycle);
                if (exp_data_q.size() == 0) begin
                    $display("error: output at %0t with no vector pending", $time);
                    errors++;
                end else begin
                    check_output(exp_data_q.pop_front(), exp_last_q.pop_front(),
                                 exp_id_q.pop_front());
                end
            end
        end
    end

    task automatic drive_case(int idx, logic [N-1:0] lane_valid);
        cur_case     = idx;
        in_valid     = lane_valid;
        in_last      = '0;
        in_last[N-1] = (case_field(idx, N + 1) != 16'h0000); // DUT ORs the lanes.
        for (int i = 0; i < N; i++) begin
            in_data[i*EW +: EW] = case_field(idx, 1 + i);
        end
    endtask

    task automatic idle_inputs();
        in_valid = '0;
        in_last  = '0;
    endtask

    task automatic send_case(int idx);
        logic taken;
        drive_case(idx, '1);
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = in_ready;
            #1;
        end
    endtask

    task automatic wait_drain();
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_quiet();
        repeat (QUIET) @(posedge clk);
        #1;
    endtask

    task automatic clear_times();
        acc_cycles.delete();
        out_cycles.delete();
    endtask

    task automatic end_test(string name, int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int   e0;
        int   sent;
        int   feed;
        int   c;
        int   p;
        logic stalled;

        void'($urandom(SEED));
        cycle        = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_case     = 0;
        rst          = 1'b1;
        in_valid     = '0;
        in_last      = '0;
        in_data      = '0;
        out_ready    = 1'b1;
        $readmemh("testbench/sfu_cases.txt", case_mem);
        for (int i = 0; i < NUM_CASES; i++) begin
            if (case_field(i, 0) != 16'(i)) begin
                $display("error: case file row %0d holds id %h", i, case_field(i, 0));
                errors++;
            end
        end

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        e0 = errors;
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("[FAIL] t=%0t after reset out_valid=%b in_ready=%b", $time,
                     out_valid, in_ready);
            errors++;
        end
        end_test("reset", e0);

        e0 = errors;
        clear_times();
        send_case(0);
        idle_inputs();
        wait_drain();
        if (acc_cycles.size() != 1 || out_cycles.size() != 1) begin
            $display("error: lone vector gave %0d outputs", out_cycles.size());
            errors++;
        end else if (out_cycles[0] - acc_cycles[0] != LATENCY) begin
            $display("[FAIL] t=%0t latency %0d, expected %0d", $time,
                     out_cycles[0] - acc_cycles[0], LATENCY);
            errors++;
        end
        end_test("latency", e0);

        e0 = errors;
        clear_times();
        for (int i = 0; i < NUM_CASES; i++) begin
            if (mask_of(i) == '1) begin
                send_case(i);
            end
        end
        idle_inputs();
        wait_drain();
        wait_quiet();
        end_test("values", e0);

        e0 = errors;
        if (out_cycles.size() != acc_cycles.size()) begin
            $display("error: %0d accepted but %0d left", acc_cycles.size(), out_cycles.size());
            errors++;
        end
        for (int i = 1; i < out_cycles.size(); i++) begin
            if (out_cycles[i] - out_cycles[i-1] != 1 || acc_cycles[i] - acc_cycles[i-1] != 1) begin
                $display("[FAIL] t=%0t gap before vector %0d", $time, i);
                errors++;
            end
        end
        end_test("throughput", e0);

        // Fill with the output stalled, then drain under random back-pressure.
        e0 = errors;
        clear_times();
        out_ready = 1'b0;
        sent      = 0;
        stalled   = 1'b0;
        c         = next_full_case(NUM_CASES - 1);
        while (!stalled && sent < 2 * CAPACITY) begin
            drive_case(c, '1);
            @(posedge clk);
            if (in_ready) begin
                sent++;
                c = next_full_case(c);
            end else begin
                stalled = 1'b1;
            end
            #1;
        end
        if (!stalled || sent != CAPACITY) begin
            $display("[FAIL] t=%0t in_ready fell=%b after %0d vectors, expected %0d",
                     $time, stalled, sent, CAPACITY);
            errors++;
        end
        feed = 0;
        while (feed < NUM_CASES || exp_data_q.size() != 0) begin
            out_ready = ($urandom % 4) != 0;
            if (feed < NUM_CASES) begin
                drive_case(c, '1);
            end else begin
                idle_inputs();
            end
            @(posedge clk);
            if (feed < NUM_CASES && in_ready) begin
                feed++;
                c = next_full_case(c);
            end
            #1;
        end
        out_ready = 1'b1;
        wait_quiet();
        if (out_cycles.size() != acc_cycles.size()) begin
            $display("error: %0d accepted but %0d left", acc_cycles.size(), out_cycles.size());
            errors++;
        end
        end_test("backpressure", e0);

        e0 = errors;
        clear_times();
        p = -1;
        for (int i = NUM_CASES - 1; i >= 0; i--) begin
            if (mask_of(i) != '1) begin
                p = i;
            end
        end
        if (p < 0) begin
            $display("error: case file has no partial lane-valid row");
            errors++;
        end else begin
            drive_case(p, mask_of(p));
            repeat (8) @(posedge clk);
            #1;
            if (acc_cycles.size() != 0 || out_cycles.size() != 0) begin
                $display("[FAIL] t=%0t partial vector accepted", $time);
                errors++;
            end
            send_case(p);
            idle_inputs();
            wait_drain();
            wait_quiet();
            if (acc_cycles.size() != 1 || out_cycles.size() != 1) begin
                $display("error: full vector after partial gave %0d outputs",
                         out_cycles.size());
                errors++;
            end
        end
        end_test("partial_valid", e0);

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/sfu_top.sv */
`default_nettype none

module sfu_top
    import sfu_pkg::*;
#(
    parameter int N = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [N-1:0]               in_valid,
    input  logic [N-1:0]               in_last,
    input  logic [N*$bits(elem_t)-1:0] in_data,
    output logic                       in_ready,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic                       out_last,
    output logic [N*$bits(elem_t)-1:0] out_data
);

    localparam int EW    = $bits(elem_t);
    localparam int DEPTH = $clog2(N) + DIV_STAGES; // Tree levels plus divider.

    elem_t  in_lanes    [N];
    elem_t  lane_result [N];
    elem_t  out_lanes   [N];
    logic   sum_valid;
    logic   sum_ready;
    sum_t   sum;
    logic   recip_valid;
    logic   recip_ready;
    recip_t recip;
    logic   advance;

    vec_stream_if #(.N(N)) cap_sum ();
    vec_stream_if #(.N(N)) cap_byp ();
    vec_stream_if #(.N(N)) byp_out ();

    for (genvar i = 0; i < N; i++) begin : g_flat
        assign in_lanes[i]          = in_data[i*EW +: EW];
        assign out_data[i*EW +: EW] = out_lanes[i];
    end

    lane_capture #(.N(N)) u_capture (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_last  (in_last),
        .in_data  (in_lanes),
        .in_ready (in_ready),
        .sum_bus  (cap_sum.src),
        .byp_bus  (cap_byp.src)
    );

    sum_tree #(.N(N)) u_tree (
        .clk       (clk),
        .rst       (rst),
        .in_bus    (cap_sum.dst),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .sum       (sum)
    );

    recip_div u_div (
        .clk         (clk),
        .rst         (rst),
        .sum_valid   (sum_valid),
        .sum_ready   (sum_ready),
        .sum         (sum),
        .recip_valid (recip_valid),
        .recip_ready (recip_ready),
        .recip       (recip)
    );

    bypass_delay #(.N(N), .DEPTH(DEPTH)) u_bypass (
        .clk     (clk),
        .rst     (rst),
        .in_bus  (cap_byp.dst),
        .out_bus (byp_out.src)
    );

    // Lanes tap the delayed vector and the shared reciprocal.
    for (genvar i = 0; i < N; i++) begin : g_lane
        lane_scale u_scale (
            .clk     (clk),
            .rst     (rst),
            .advance (advance),
            .elem    (byp_out.data[i]),
            .recip   (recip),
            .result  (lane_result[i])
        );
    end

    result_collect #(.N(N)) u_collect (
        .clk         (clk),
        .rst         (rst),
        .recip_valid (recip_valid),
        .recip_ready (recip_ready),
        .byp_bus     (byp_out.dst),
        .lane_result (lane_result),
        .advance     (advance),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_last    (out_last),
        .out_data    (out_lanes)
    );

endmodule

`default_nettype wire

/* design/result_collect.sv */
`default_nettype none

module result_collect
    import sfu_pkg::*;
#(
    parameter int N = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      recip_valid,
    output logic      recip_ready,
    vec_stream_if.dst byp_bus,
    input  elem_t     lane_result [N],
    output logic      advance,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      out_last,
    output elem_t     out_data [N]
);

    logic lane_valid;
    logic lane_last;
    logic lane_ready;
    logic out_load;
    logic pair_valid;

    assign out_load   = !out_valid || out_ready;
    assign lane_ready = !lane_valid || out_load;
    assign pair_valid = recip_valid && byp_bus.valid;

    // Join takes both sides at once.
    assign advance       = pair_valid && lane_ready;
    assign recip_ready   = advance;
    assign byp_bus.ready = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (lane_ready) begin
                lane_valid <= pair_valid;
            end
            if (out_load) begin
                out_valid <= lane_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            lane_last <= byp_bus.last; // Results themselves sit in the lane scalers.
        end
        if (out_load && lane_valid) begin
            out_data <= lane_result;
            out_last <= lane_last;
        end
    end

endmodule

`default_nettype wire

/* design/lane_scale.sv */
`default_nettype none

module lane_scale
    import sfu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   advance,
    input  elem_t  elem,
    input  recip_t recip,
    output elem_t  result
);

    localparam elem_t ELEM_MAX = '1;

    prod_t prod;
    prod_t shifted;

    assign prod    = prod_t'(elem) * prod_t'(recip);
    assign shifted = prod >> OUT_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (advance) begin
            // Single nonzero lane gives 2^16, clipped here.
            result <= (shifted > prod_t'(ELEM_MAX)) ? ELEM_MAX : elem_t'(shifted);
        end
    end

endmodule

`default_nettype wire

/* design/bypass_delay.sv */
`default_nettype none

module bypass_delay
    import sfu_pkg::*;
#(
    parameter int N     = 8,
    parameter int DEPTH = 28
) (
    input  logic      clk,
    input  logic      rst,
    vec_stream_if.dst in_bus,
    vec_stream_if.src out_bus
);

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] last_q;
    logic [DEPTH-1:0] adv;
    elem_t            data_q [DEPTH][N];

    // Same advance rule as the sum path keeps the vector beside its sum.
    always_comb begin
        adv[DEPTH-1] = !valid_q[DEPTH-1] || out_bus.ready;
        for (int s = DEPTH - 2; s >= 0; s--) begin
            adv[s] = !valid_q[s] || adv[s + 1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            if (adv[0]) begin
                valid_q[0] <= in_bus.valid;
            end
            for (int s = 1; s < DEPTH; s++) begin
                if (adv[s]) begin
                    valid_q[s] <= valid_q[s - 1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv[0]) begin
            data_q[0] <= in_bus.data;
            last_q[0] <= in_bus.last;
        end
        for (int s = 1; s < DEPTH; s++) begin
            if (adv[s]) begin
                data_q[s] <= data_q[s - 1];
                last_q[s] <= last_q[s - 1];
            end
        end
    end

    assign in_bus.ready  = adv[0];
    assign out_bus.valid = valid_q[DEPTH-1];
    assign out_bus.last  = last_q[DEPTH-1];
    assign out_bus.data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

/* design/recip_div.sv */
`default_nettype none

module recip_div
    import sfu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   sum_valid,
    output logic   sum_ready,
    input  sum_t   sum,
    output logic   recip_valid,
    input  logic   recip_ready,
    output recip_t recip
);

    typedef logic [RECIP_SHIFT:0] rem_t;

    localparam recip_t DIVIDEND = recip_t'(1) << RECIP_SHIFT;
    localparam int     LAST     = DIV_STAGES - 1;

    logic [DIV_STAGES-1:0] st_valid;
    logic [DIV_STAGES-1:0] st_zero;
    logic [DIV_STAGES-1:0] adv;
    rem_t                  st_rem [DIV_STAGES];
    recip_t                st_quo [DIV_STAGES];
    sum_t                  st_div [DIV_STAGES];

    logic [DIV_STAGES-1:0] nx_valid;
    logic [DIV_STAGES-1:0] nx_zero;
    rem_t                  nx_rem [DIV_STAGES];
    recip_t                nx_quo [DIV_STAGES];
    sum_t                  nx_div [DIV_STAGES];

    always_comb begin
        adv[LAST] = !st_valid[LAST] || recip_ready;
        for (int s = LAST - 1; s >= 0; s--) begin
            adv[s] = !st_valid[s] || adv[s + 1];
        end
    end

    // Restoring step per stage, dividend bits MSB first.
    always_comb begin
        rem_t   prev_rem;
        recip_t prev_quo;
        rem_t   trial;
        logic   fits;

        for (int s = 0; s < DIV_STAGES; s++) begin
            if (s == 0) begin
                nx_valid[s] = sum_valid;
                nx_zero[s]  = (sum == '0); // Marked at entry.
                nx_div[s]   = sum;
                prev_rem    = '0;
                prev_quo    = '0;
            end else begin
                nx_valid[s] = st_valid[s - 1];
                nx_zero[s]  = st_zero[s - 1];
                nx_div[s]   = st_div[s - 1];
                prev_rem    = st_rem[s - 1];
                prev_quo    = st_quo[s - 1];
            end
            trial     = {prev_rem[RECIP_SHIFT-1:0], DIVIDEND[LAST - s]};
            fits      = trial >= rem_t'(nx_div[s]);
            nx_rem[s] = fits ? trial - rem_t'(nx_div[s]) : trial;
            nx_quo[s] = {prev_quo[DIV_STAGES-2:0], fits};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= '0;
        end else begin
            for (int s = 0; s < DIV_STAGES; s++) begin
                if (adv[s]) begin
                    st_valid[s] <= nx_valid[s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < DIV_STAGES; s++) begin
            if (adv[s]) begin
                st_zero[s] <= nx_zero[s];
                st_rem[s]  <= nx_rem[s];
                st_quo[s]  <= nx_quo[s];
                st_div[s]  <= nx_div[s];
            end
        end
    end

    assign sum_ready   = adv[0];
    assign recip_valid = st_valid[LAST];
    assign recip       = st_zero[LAST] ? '0 : st_quo[LAST]; // Sum of 0 gives 0.

endmodule

`default_nettype wire

/* design/sum_tree.sv */
`default_nettype none

module sum_tree
    import sfu_pkg::*;
#(
    parameter int N = 8
) (
    input  logic      clk,
    input  logic      rst,
    vec_stream_if.dst in_bus,
    output logic      sum_valid,
    input  logic      sum_ready,
    output sum_t      sum
);

    localparam int LEVELS = $clog2(N);

    sum_t              node [1:N-1]; // Heap order, root at index 1.
    logic [LEVELS-1:0] lvl_valid;    // Level 0 sits next to the lanes.
    logic [LEVELS-1:0] adv;

    // A level moves when empty or when the next one takes.
    always_comb begin
        adv[LEVELS-1] = !lvl_valid[LEVELS-1] || sum_ready;
        for (int l = LEVELS - 2; l >= 0; l--) begin
            adv[l] = !lvl_valid[l] || adv[l + 1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lvl_valid <= '0;
        end else begin
            if (adv[0]) begin
                lvl_valid[0] <= in_bus.valid;
            end
            for (int l = 1; l < LEVELS; l++) begin
                if (adv[l]) begin
                    lvl_valid[l] <= lvl_valid[l - 1];
                end
            end
        end
    end

    for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
        for (genvar k = (N >> (l + 1)); k < (N >> l); k++) begin : g_node
            sum_t lhs;
            sum_t rhs;

            if (l == 0) begin : g_leaf
                assign lhs = sum_t'(in_bus.data[2 * k - N]);
                assign rhs = sum_t'(in_bus.data[2 * k + 1 - N]);
            end else begin : g_inner
                assign lhs = node[2 * k];
                assign rhs = node[2 * k + 1];
            end

            always_ff @(posedge clk) begin
                if (adv[l]) begin
                    node[k] <= lhs + rhs;
                end
            end
        end
    end

    assign in_bus.ready = adv[0];
    assign sum_valid    = lvl_valid[LEVELS-1];
    assign sum          = node[1];

endmodule

`default_nettype wire

/* design/lane_capture.sv */
`default_nettype none

module lane_capture
    import sfu_pkg::*;
#(
    parameter int N = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [N-1:0] in_valid,
    input  logic [N-1:0] in_last,
    input  elem_t        in_data [N],
    output logic         in_ready,
    vec_stream_if.src    sum_bus,
    vec_stream_if.src    byp_bus
);

    logic  full;
    logic  last_q;
    elem_t data_q [N];
    logic  take;
    logic  accept;

    // Fork completes only when both paths take in the same cycle.
    assign take     = full && sum_bus.ready && byp_bus.ready;
    assign in_ready = !full || take;
    assign accept   = (&in_valid) && in_ready; // Partial vectors wait.

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in_data;
            last_q <= |in_last;
        end
    end

    // Each side sees valid only if the other side can take too.
    assign sum_bus.valid = full && byp_bus.ready;
    assign byp_bus.valid = full && sum_bus.ready;
    assign sum_bus.data  = data_q;
    assign byp_bus.data  = data_q;
    assign sum_bus.last  = last_q;
    assign byp_bus.last  = last_q;

endmodule

`default_nettype wire

/* design/vec_stream_if.sv */
`default_nettype none

// One vector of N lanes with a single valid, ready and last.
interface vec_stream_if
    import sfu_pkg::*;
#(
    parameter int N = 8
);

    logic  valid;
    logic  ready;
    logic  last;
    elem_t data [N];

    modport src (
        output valid,
        output last,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  last,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* design/sfu_pkg.sv */
`default_nettype none

package sfu_pkg;

    typedef logic [15:0] elem_t;   // Lane value, or a fraction of 65536 at the output.
    typedef logic [23:0] sum_t;    // Vector sum, enough for 256 lanes.
    typedef logic [24:0] recip_t;  // floor(2^24 / sum), up to 2^24.
    typedef logic [40:0] prod_t;   // Lane value times reciprocal.

    localparam int RECIP_SHIFT = 24; // Fractional weight of the reciprocal.
    localparam int OUT_SHIFT   = 8;
    localparam int DIV_STAGES  = 25; // One quotient bit per stage.

endpackage

`default_nettype wire
